// File: list.f
hdl/tetris_geom_pkg.sv
hdl/tetris_ctrl_pkg.sv
hdl/tetris_controls.sv
hdl/tetris_engine.sv
hdl/tetris_board.sv
hdl/tetris_display.sv
hdl/tetris_top.sv
dv/tetris_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tetris_tb -f list.f -o tetris_sim
	./obj_dir/tetris_sim | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: dv/tetris_tb.sv
module tetris_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tetris_geom_pkg::*;

  typedef enum int {ACT_START, ACT_LEFT, ACT_RIGHT, ACT_DOWN, ACT_DROP} act_t;
  typedef enum int {M_IDLE, M_READY, M_FALL, M_OVER} mode_t;
  typedef struct {
    act_t   act;
    piece_t kind;   // piece_sel for the whole step
    int     count;
    lines_t lines;  // expected at the end of the step
    logic   over;
  } step_t;

  logic   clk;
  logic   rst;
  logic   en;
  logic   left;
  logic   right;
  logic   down;
  piece_t piece_sel;
  board_t grid;
  lines_t lines;
  logic   game_over;
  logic   ready;

  step_t  steps[$];
  board_t m_board;  // settled cells of the model
  row_t   m_rows[4];
  int     m_top;
  mode_t  m_mode;
  logic   m_locked;

  tetris_top i_dut (.clk(clk), .rst(rst), .en(en), .left(left), .right(right), .down(down),
                    .piece_sel(piece_sel), .grid(grid), .lines(lines),
                    .game_over(game_over), .ready(ready));

  always #2 clk = ~clk;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_grid(string name, board_t got, board_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_lines(string name, lines_t got, lines_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_ready_or_over();
    int n;
    n = 0;
    @(negedge clk);
    while (!(ready || game_over)) begin
      if (n == 200) begin
        $display("timed out waiting for ready or game_over");
        abort_run();
      end
      n++;
      @(negedge clk);
    end
  endtask

  ////////////////////
  // playfield model
  ////////////////////
  function automatic logic collides(row_t rows[4], int top, board_t b);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < 4; k++)
      for (int c = 0; c < board_cols; c++)
        if (rows[k][c]) hit |= (top + k >= board_rows) ? 1'b1 : b[top + k][c];
    return hit;
  endfunction

  function automatic board_t expected_grid();
    board_t g;
    g = m_board;
    if (m_mode == M_FALL)
      for (int k = 0; k < 4; k++)
        for (int c = 0; c < board_cols; c++)
          if (m_rows[k][c]) g[m_top + k][c] = 1'b1;
    return g;
  endfunction

  task automatic spawn_piece(piece_t kind);
    m_rows = shape_rows[int'(kind)];
    m_top  = spawn_row;
    m_mode = collides(m_rows, m_top, m_board) ? M_OVER : M_FALL;
  endtask

  task automatic shift_piece(logic to_left);
    row_t cand[4];
    logic blocked;
    blocked = 1'b0;
    for (int k = 0; k < 4; k++) begin
      blocked |= to_left ? m_rows[k][0] : m_rows[k][board_cols-1];  // wall
      cand[k] = to_left ? m_rows[k] >> 1 : m_rows[k] << 1;
    end
    if (!blocked && !collides(cand, m_top, m_board)) m_rows = cand;
  endtask

  task automatic lower_piece(piece_t next);
    board_t kept;
    int     w;
    m_locked = 1'b0;
    if (!collides(m_rows, m_top + 1, m_board)) begin
      m_top++;
    end else begin
      for (int k = 0; k < 4; k++)
        for (int c = 0; c < board_cols; c++)
          if (m_rows[k][c]) m_board[m_top + k][c] = 1'b1;
      kept = '0;
      w = board_rows - 1;
      for (int r = board_rows - 1; r >= 0; r--) begin
        if (!(&m_board[r])) begin  // full rows vanish and the rest sink
          kept[w] = m_board[r];
          w--;
        end
      end
      m_board  = kept;
      m_locked = 1'b1;
      spawn_piece(next);
    end
  endtask

  task automatic apply_press(act_t a, piece_t kind);
    if (a == ACT_START) begin
      if (m_mode == M_IDLE) m_mode = M_READY;
      else if (m_mode == M_READY) spawn_piece(kind);
      else if (m_mode == M_OVER) begin
        m_board = '0;
        m_mode  = M_IDLE;
      end
    end else if (m_mode == M_FALL) begin
      if (a == ACT_LEFT) shift_piece(1'b1);
      else if (a == ACT_RIGHT) shift_piece(1'b0);
      else lower_piece(kind);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  task automatic press(act_t a);
    @(posedge clk);
    case (a)
      ACT_START: en <= 1'b1;
      ACT_LEFT:  left <= 1'b1;
      ACT_RIGHT: right <= 1'b1;
      default:   down <= 1'b1;
    endcase
    @(posedge clk);
    en    <= 1'b0;
    left  <= 1'b0;
    right <= 1'b0;
    down  <= 1'b0;
  endtask

  task automatic run_press(act_t a, piece_t kind);
    if (a != ACT_START) wait_ready_or_over();
    press(a);
    apply_press(a, kind);
    repeat (2) @(posedge clk);  // controls and engine latency
    if (m_mode == M_FALL || m_mode == M_OVER) wait_ready_or_over();
    @(posedge clk);  // display register
    @(negedge clk);
    check_grid("grid", grid, expected_grid());
    check_flag("ready", ready, m_mode == M_FALL);
    check_flag("game_over", game_over, m_mode == M_OVER);
  endtask

  task automatic add_step(act_t a, piece_t kind, int n, lines_t l, logic o);
    step_t s;
    s.act   = a;
    s.kind  = kind;
    s.count = n;
    s.lines = l;
    s.over  = o;
    steps.push_back(s);
  endtask

  initial begin
    int cols[5];
    int j;
    int t;
    int presses;
    clk = 1'b0;
    rst = 1'b1;
    en = 1'b0;
    left = 1'b0;
    right = 1'b0;
    down = 1'b0;
    piece_sel = O;
    void'($urandom(32'h0a25e033));
    m_board = '0;
    m_rows = '{default: '0};
    m_top = 0;
    m_mode = M_IDLE;
    m_locked = 1'b0;

    add_step(ACT_START, O, 1, 16'd0, 1'b0);
    add_step(ACT_START, O, 1, 16'd0, 1'b0);
    cols = '{0, 2, 4, 6, 8};
    for (int i = 4; i > 0; i--) begin  // shuffle the O columns
      j = $urandom_range(i, 0);
      t = cols[i];
      cols[i] = cols[j];
      cols[j] = t;
    end
    for (int i = 0; i < 5; i++) begin
      if (cols[i] < 4) add_step(ACT_LEFT, O, 4 - cols[i], 16'd0, 1'b0);
      if (cols[i] > 4) add_step(ACT_RIGHT, O, cols[i] - 4, 16'd0, 1'b0);
      add_step(ACT_DROP, (i == 4) ? I : O, 1, (i == 4) ? 16'd2 : 16'd0, 1'b0);
    end
    add_step(ACT_LEFT, I, 4, 16'd2, 1'b0);   // last one hits the wall
    add_step(ACT_RIGHT, I, 7, 16'd2, 1'b0);
    add_step(ACT_DROP, T, 1, 16'd2, 1'b0);
    add_step(ACT_DOWN, T, 18, 16'd2, 1'b0);  // T rests beside the I
    add_step(ACT_RIGHT, T, 1, 16'd2, 1'b0);
    add_step(ACT_DOWN, S, 1, 16'd2, 1'b0);
    add_step(ACT_DROP, Z, 1, 16'd2, 1'b0);
    add_step(ACT_DROP, J, 1, 16'd2, 1'b0);
    add_step(ACT_DROP, L, 1, 16'd2, 1'b0);
    add_step(ACT_DROP, O, 20, 16'd2, 1'b1);  // stack until spawn fails
    add_step(ACT_START, O, 1, 16'd2, 1'b0);
    add_step(ACT_START, O, 1, 16'd2, 1'b0);
    add_step(ACT_START, Z, 1, 16'd2, 1'b0);

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_grid("grid", grid, '0);
    check_lines("lines", lines, '0);
    check_flag("game_over", game_over, 1'b0);
    check_flag("ready", ready, 1'b0);

    foreach (steps[i]) begin
      @(posedge clk);
      piece_sel <= steps[i].kind;
      if (steps[i].act == ACT_DROP) begin
        for (int p = 0; p < steps[i].count && m_mode == M_FALL; p++) begin
          presses  = 0;
          m_locked = 1'b0;
          while (!m_locked) begin
            if (presses == 25) begin
              $display("piece did not lock after 25 down presses");
              abort_run();
            end
            run_press(ACT_DOWN, steps[i].kind);
            presses++;
          end
        end
      end else begin
        for (int p = 0; p < steps[i].count; p++) run_press(steps[i].act, steps[i].kind);
      end
      check_lines("lines", lines, steps[i].lines);
      check_flag("game_over", game_over, steps[i].over);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: hdl/tetris_top.sv
module tetris_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  logic                    left,
  input  logic                    right,
  input  logic                    down,
  input  tetris_geom_pkg::piece_t piece_sel,
  output tetris_geom_pkg::board_t grid,
  output tetris_geom_pkg::lines_t lines,
  output logic                    game_over,
  output logic                    ready
);
  import tetris_geom_pkg::*;
  import tetris_ctrl_pkg::*;

  cmd_t         cmd;
  piece_cells_t piece;
  board_t       board;
  logic         clearing;
  logic         piece_valid;
  logic         lock;
  logic         wipe;

  tetris_controls i_controls (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .left  (left),
    .right (right),
    .down  (down),
    .cmd   (cmd)
  );

  tetris_engine i_engine (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .piece_sel   (piece_sel),
    .board       (board),
    .clearing    (clearing),
    .piece       (piece),
    .piece_valid (piece_valid),
    .lock        (lock),
    .wipe        (wipe),
    .ready       (ready),
    .game_over   (game_over)
  );

  tetris_board i_board (
    .clk      (clk),
    .rst      (rst),
    .lock     (lock),
    .piece    (piece),
    .wipe     (wipe),
    .board    (board),
    .clearing (clearing),
    .lines    (lines)
  );

  tetris_display i_display (
    .clk         (clk),
    .rst         (rst),
    .board       (board),
    .piece       (piece),
    .piece_valid (piece_valid),
    .grid        (grid)
  );

endmodule

// File: hdl/tetris_display.sv
module tetris_display (
  input  logic                          clk,
  input  logic                          rst,
  input  tetris_geom_pkg::board_t       board,
  input  tetris_ctrl_pkg::piece_cells_t piece,
  input  logic                          piece_valid,
  output tetris_geom_pkg::board_t       grid
);
  import tetris_ctrl_pkg::*;

  // settled cells plus the falling piece one cycle behind
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grid <= '0;
    end else if (piece_valid) begin
      grid <= overlay(board, piece);
    end else begin
      grid <= board;
    end
  end

endmodule

// File: hdl/tetris_board.sv
module tetris_board (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          lock,
  input  tetris_ctrl_pkg::piece_cells_t piece,
  input  logic                          wipe,
  output tetris_geom_pkg::board_t       board,
  output logic                          clearing,
  output tetris_geom_pkg::lines_t       lines
);
  import tetris_geom_pkg::*;
  import tetris_ctrl_pkg::*;

  board_t   merged;    // board with the piece locked in
  board_t   shifted;   // board with the lowest full row removed
  logic     found;
  row_idx_t full_row;

  assign merged = overlay(board, piece);

  ////////////////////
  // lowest full row
  ////////////////////
  always_comb begin
    found    = 1'b0;
    full_row = '0;
    for (int r = 0; r < board_rows; r++) begin
      if (&board[r]) begin
        found    = 1'b1;
        full_row = row_idx_t'(r);  // last hit is the lowest
      end
    end
    for (int r = 0; r < board_rows; r++) begin
      if (r > int'(full_row)) begin
        shifted[r] = board[r];
      end else if (r == 0) begin
        shifted[r] = '0;  // empty row in at the top
      end else begin
        shifted[r] = board[r-1];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      board    <= '0;
      clearing <= 1'b0;
      lines    <= '0;
    end else if (wipe) begin
      board <= '0;  // lines survive a new game
    end else if (lock) begin
      board    <= merged;
      clearing <= 1'b1;
    end else if (clearing) begin
      if (found) begin
        board <= shifted;
        lines <= lines + 1'b1;
      end else begin
        clearing <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) lock |-> !clearing);

endmodule

// File: hdl/tetris_engine.sv
module tetris_engine (
  input  logic                          clk,
  input  logic                          rst,
  input  tetris_ctrl_pkg::cmd_t         cmd,
  input  tetris_geom_pkg::piece_t       piece_sel,
  input  tetris_geom_pkg::board_t       board,
  input  logic                          clearing,
  output tetris_ctrl_pkg::piece_cells_t piece,
  output logic                          piece_valid,
  output logic                          lock,
  output logic                          wipe,
  output logic                          ready,
  output logic                          game_over
);
  import tetris_geom_pkg::*;
  import tetris_ctrl_pkg::*;

  game_state_t  state, state_n;
  piece_cells_t piece_n;
  piece_cells_t spawn_cells, cand_left, cand_right, cand_down;
  row_t         occupied;  // columns used by the piece in any box row
  logic         rests;     // piece cannot go one row lower

  // overlap with settled cells or a cell below the floor
  function automatic logic hits(piece_cells_t p, board_t b);
    int   idx;
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < 4; k++) begin
      idx = int'(p.top_row) + k;
      if (p.rows[k] != '0) begin
        if (idx >= board_rows) begin
          hit = 1'b1;
        end else if ((p.rows[k] & b[idx]) != '0) begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  ////////////////////
  // candidate positions
  ////////////////////
  always_comb begin
    occupied = piece.rows[0] | piece.rows[1] | piece.rows[2] | piece.rows[3];
    spawn_cells.top_row = row_idx_t'(spawn_row);
    cand_left  = piece;
    cand_right = piece;
    cand_down  = piece;
    cand_down.top_row = piece.top_row + 1'b1;
    for (int k = 0; k < 4; k++) begin
      spawn_cells.rows[k] = shape_rows[piece_sel][k];
      cand_left.rows[k]   = piece.rows[k] >> 1;  // bit 0 is leftmost
      cand_right.rows[k]  = piece.rows[k] << 1;
    end
    rests = hits(cand_down, board);
  end

  ////////////////////
  // game FSM
  ////////////////////
  always_comb begin
    state_n = state;
    piece_n = piece;
    case (state)
      IDLE:  if (cmd.start) state_n = READY;
      READY: if (cmd.start) state_n = SPAWN;
      SPAWN: begin
        piece_n = spawn_cells;
        state_n = hits(spawn_cells, board) ? GAME_OVER : FALL;
      end
      FALL: begin
        if (cmd.down) begin
          if (rests) begin
            state_n = LOCK;  // resting on floor or stack
          end else begin
            piece_n = cand_down;
          end
        end else if (cmd.left && !occupied[0] && !hits(cand_left, board)) begin
          piece_n = cand_left;
        end else if (cmd.right && !occupied[board_cols-1] && !hits(cand_right, board)) begin
          piece_n = cand_right;
        end
      end
      LOCK:      state_n = CLEAR;
      CLEAR:     if (!clearing) state_n = SPAWN;
      GAME_OVER: if (cmd.start) state_n = IDLE;
      default:   state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_n;
    end
  end

  always_ff @(posedge clk) begin
    piece <= piece_n;
  end

  assign piece_valid = (state == FALL) || (state == LOCK);
  assign lock        = (state == LOCK);
  assign wipe        = (state == GAME_OVER) && cmd.start;
  assign ready       = (state == FALL);
  assign game_over   = (state == GAME_OVER);

  // the piece being locked rests on the floor or the stack
  assert property (@(posedge clk) disable iff (rst)
    lock |-> rests);

  // the failed spawn overlaps the stack for all of game over
  assert property (@(posedge clk) disable iff (rst)
    game_over |-> hits(piece, board));

endmodule

// File: hdl/tetris_controls.sv
module tetris_controls (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  logic                  left,
  input  logic                  right,
  input  logic                  down,
  output tetris_ctrl_pkg::cmd_t cmd
);
  import tetris_ctrl_pkg::*;

  cmd_t btn;
  cmd_t btn_q;  // previous sample

  always_comb begin
    btn.start = en;
    btn.left  = left;
    btn.right = right;
    btn.down  = down;
  end

  // one pulse on each rising edge of a level
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      btn_q <= '0;
      cmd   <= '0;
    end else begin
      btn_q <= btn;
      cmd   <= btn & ~btn_q;
    end
  end

  // two move pulses together only when two buttons rose on the same edge
  assert property (@(posedge clk) disable iff (rst)
    $countones({cmd.left, cmd.right, cmd.down}) > 1 |->
      $countones({$past(left) & ~$past(left, 2),
                  $past(right) & ~$past(right, 2),
                  $past(down) & ~$past(down, 2)}) > 1);

endmodule

// File: hdl/tetris_ctrl_pkg.sv
package tetris_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    READY,
    SPAWN,
    FALL,
    LOCK,
    CLEAR,
    GAME_OVER
  } game_state_t;

  typedef struct packed {
    logic start;
    logic left;
    logic right;
    logic down;
  } cmd_t;

  typedef struct packed {
    tetris_geom_pkg::row_idx_t      top_row;
    tetris_geom_pkg::row_t    [3:0] rows;  // rows[k] is box row k
  } piece_cells_t;

  // ORs the piece box into the board and skips rows past the bottom
  function automatic tetris_geom_pkg::board_t overlay(tetris_geom_pkg::board_t b,
                                                      piece_cells_t p);
    tetris_geom_pkg::board_t o;
    int idx;
    o = b;
    for (int k = 0; k < 4; k++) begin
      idx = int'(p.top_row) + k;
      if (idx < tetris_geom_pkg::board_rows) begin
        o[idx] = o[idx] | p.rows[k];
      end
    end
    return o;
  endfunction

endpackage

// File: hdl/tetris_geom_pkg.sv
package tetris_geom_pkg;

  ////////////////////
  // board dimensions
  ////////////////////
  localparam int board_cols = 10;
  localparam int board_rows = 20;  // visible rows above an implied floor
  localparam int spawn_row  = 0;

  typedef logic [board_cols-1:0] row_t;  // bit 0 is the leftmost column
  typedef logic [4:0]            row_idx_t;  // row 0 at the top
  typedef row_t [board_rows-1:0] board_t;
  typedef logic [15:0]           lines_t;

  typedef enum logic [2:0] {
    I,
    O,
    T,
    S,
    Z,
    J,
    L
  } piece_t;

  ////////////////////
  // shapes at spawn columns in box rows 0..3
  ////////////////////
  localparam row_t shape_rows [7][4] = '{
    '{10'b0001111000, 10'b0000000000, 10'b0000000000, 10'b0000000000},  // I
    '{10'b0000110000, 10'b0000110000, 10'b0000000000, 10'b0000000000},  // O
    '{10'b0000010000, 10'b0000111000, 10'b0000000000, 10'b0000000000},  // T
    '{10'b0000110000, 10'b0000011000, 10'b0000000000, 10'b0000000000},  // S
    '{10'b0000011000, 10'b0000110000, 10'b0000000000, 10'b0000000000},  // Z
    '{10'b0000001000, 10'b0000111000, 10'b0000000000, 10'b0000000000},  // J
    '{10'b0000100000, 10'b0000111000, 10'b0000000000, 10'b0000000000}   // L
  };

endpackage
